//--- hw/classifier_pkg.sv
package classifier_pkg;

    // one byte of the host stream
    localparam int data_w = 8;

    // 7x7 pooled picture
    localparam int num_features = 49;

    // digits 0 to 9
    localparam int num_classes = 10;

    localparam int class_w = 4;
    localparam int feat_w = 6;

    // holds 49*255*255 + 255 without wrapping
    localparam int acc_w = 22;

    // 'R', the read command byte that opens a frame
    localparam logic [data_w-1:0] header_code = 8'h52;

    // token buffer between parser and classifier
    localparam int fifo_depth = 4;

    // which part of the frame a byte belongs to
    typedef enum logic [1:0] {
        sec_feature,
        sec_weight,
        sec_bias
    } section_t;

    // one tagged frame byte, 20 bits
    typedef struct packed {
        section_t section;
        logic [class_w-1:0] class_idx;
        logic [feat_w-1:0] feat_idx;
        logic [data_w-1:0] value;
    } token_t;

endpackage

//--- hw/token_stream_if.sv
`timescale 1ns/1ps

interface token_stream_if;

    logic valid;
    logic ready;
    classifier_pkg::token_t token;

    // transfer on a rising edge with valid and ready both high
    // a waiting token stays put until it is taken

    modport source (
        output valid,
        output token,
        input ready
    );

    modport sink (
        input valid,
        input token,
        output ready
    );

endinterface

//--- hw/frame_parser.sv
`timescale 1ns/1ps

module frame_parser (
    input logic clk,
    input logic reset,
    input logic [classifier_pkg::data_w-1:0] in_data,
    input logic in_valid,
    output logic in_ready,
    token_stream_if.source tokens
);

    typedef logic [classifier_pkg::class_w-1:0] class_t;
    typedef logic [classifier_pkg::feat_w-1:0] feat_t;

    logic hunting;
    classifier_pkg::section_t sec;
    class_t cls;
    feat_t feat;
    logic accept;
    logic fire;
    logic last_feat;
    logic last_class;

    // straight through, no buffering here
    assign in_ready = tokens.ready;
    assign accept = in_valid && in_ready;
    assign fire = accept && !hunting;

    // header and junk bytes never reach the stream
    assign tokens.valid = in_valid && !hunting;
    assign tokens.token.section = sec;
    assign tokens.token.class_idx = cls;
    assign tokens.token.feat_idx = feat;
    assign tokens.token.value = in_data;

    assign last_feat = (feat == feat_t'(classifier_pkg::num_features - 1));
    assign last_class = (cls == class_t'(classifier_pkg::num_classes - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hunting <= 1'b1;
            sec <= classifier_pkg::sec_feature;
            cls <= '0;
            feat <= '0;
        end else if (accept && hunting) begin
            if (in_data == classifier_pkg::header_code) begin
                hunting <= 1'b0;
                sec <= classifier_pkg::sec_feature;
                cls <= '0;
                feat <= '0;
            end
        end else if (fire) begin
            case (sec)
                classifier_pkg::sec_feature: begin
                    feat <= last_feat ? '0 : feat + 1'b1;
                    if (last_feat) begin
                        sec <= classifier_pkg::sec_weight;
                    end
                end
                classifier_pkg::sec_weight: begin
                    // class-major, 49 weights per class
                    feat <= last_feat ? '0 : feat + 1'b1;
                    if (last_feat) begin
                        cls <= last_class ? '0 : cls + 1'b1;
                        if (last_class) begin
                            sec <= classifier_pkg::sec_bias;
                        end
                    end
                end
                default: begin
                    // one bias per class, then back to hunting
                    cls <= last_class ? '0 : cls + 1'b1;
                    if (last_class) begin
                        sec <= classifier_pkg::sec_feature;
                        hunting <= 1'b1;
                    end
                end
            endcase
        end
    end

    // while hunting only an accepted header can open the stream
    a_no_token_hunting: assert property (@(posedge clk) disable iff (reset)
        (hunting && !(accept && in_data == classifier_pkg::header_code))
            |=> !tokens.valid);

endmodule

//--- hw/token_fifo.sv
`timescale 1ns/1ps

module token_fifo (
    input logic clk,
    input logic reset,
    token_stream_if.sink upstream,
    token_stream_if.source downstream
);

    typedef logic [$clog2(classifier_pkg::fifo_depth)-1:0] ptr_t;
    typedef logic [$clog2(classifier_pkg::fifo_depth + 1)-1:0] count_t;

    classifier_pkg::token_t mem [classifier_pkg::fifo_depth];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    count_t count;
    logic push;
    logic pop;

    assign upstream.ready = (count != count_t'(classifier_pkg::fifo_depth));
    assign downstream.valid = (count != '0);
    assign downstream.token = mem[rd_ptr];

    assign push = upstream.valid && upstream.ready;
    assign pop = downstream.valid && downstream.ready;

    // storage only, pointers say what is live
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= upstream.token;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_t'(classifier_pkg::fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(classifier_pkg::fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // full FIFO keeps its waiting head untouched
    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        (count == count_t'(classifier_pkg::fifo_depth) && !pop)
            |=> (count == count_t'(classifier_pkg::fifo_depth)
                 && $stable(downstream.token)));

    // nothing leaves an empty FIFO
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        (count == '0 && !push) |=> (count == '0));

endmodule

//--- hw/dense_argmax.sv
`timescale 1ns/1ps

module dense_argmax (
    input logic clk,
    input logic reset,
    token_stream_if.sink tokens,
    output logic [classifier_pkg::class_w-1:0] answer,
    output logic answer_valid
);

    typedef logic [classifier_pkg::acc_w-1:0] acc_t;
    typedef logic [classifier_pkg::class_w-1:0] class_t;

    typedef enum logic [1:0] {
        st_accum,
        st_scan,
        st_finish
    } state_t;

    state_t state;
    class_t scan_idx;
    class_t best_idx;
    acc_t best_score;
    acc_t scores [classifier_pkg::num_classes];
    logic [classifier_pkg::data_w-1:0] features [classifier_pkg::num_features];
    logic [2*classifier_pkg::data_w-1:0] product;
    logic fire;
    logic first_feature;
    logic last_bias;

    // pause the stream while the scores are walked
    assign tokens.ready = (state == st_accum);
    assign fire = tokens.valid && tokens.ready;

    assign first_feature = (tokens.token.section == classifier_pkg::sec_feature) &&
                           (tokens.token.feat_idx == '0);
    assign last_bias = (tokens.token.section == classifier_pkg::sec_bias) &&
                       (tokens.token.class_idx == class_t'(classifier_pkg::num_classes - 1));

    // weight times the stored feature of the same position
    assign product = tokens.token.value * features[tokens.token.feat_idx];

    always_ff @(posedge clk) begin
        if (fire) begin
            case (tokens.token.section)
                classifier_pkg::sec_feature: begin
                    features[tokens.token.feat_idx] <= tokens.token.value;
                    // new frame starts from zero
                    if (first_feature) begin
                        for (int i = 0; i < classifier_pkg::num_classes; i++) begin
                            scores[i] <= '0;
                        end
                    end
                end
                classifier_pkg::sec_weight: begin
                    scores[tokens.token.class_idx] <=
                        scores[tokens.token.class_idx] + acc_t'(product);
                end
                classifier_pkg::sec_bias: begin
                    scores[tokens.token.class_idx] <=
                        scores[tokens.token.class_idx] + acc_t'(tokens.token.value);
                end
                default: begin
                end
            endcase
        end

        // running maximum, only strictly greater replaces so ties keep the lower class
        if (fire && last_bias) begin
            best_score <= '0;
            best_idx <= '0;
        end else if (state == st_scan && scores[scan_idx] > best_score) begin
            best_score <= scores[scan_idx];
            best_idx <= scan_idx;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_accum;
            scan_idx <= '0;
            answer <= '0;
            answer_valid <= 1'b0;
        end else begin
            case (state)
                st_accum: begin
                    if (fire && first_feature) begin
                        answer_valid <= 1'b0;
                    end
                    if (fire && last_bias) begin
                        state <= st_scan;
                        scan_idx <= '0;
                    end
                end
                st_scan: begin
                    // one score per cycle
                    if (scan_idx == class_t'(classifier_pkg::num_classes - 1)) begin
                        state <= st_finish;
                    end else begin
                        scan_idx <= scan_idx + 1'b1;
                    end
                end
                default: begin
                    answer <= best_idx;
                    answer_valid <= 1'b1;
                    state <= st_accum;
                end
            endcase
        end
    end

    // result holds until the next frame begins
    a_answer_held: assert property (@(posedge clk) disable iff (reset)
        (answer_valid && !fire) |=> (answer_valid && $stable(answer)));

endmodule

//--- hw/digit_classifier.sv
`timescale 1ns/1ps

module digit_classifier (
    input logic clk,
    input logic reset,
    input logic [classifier_pkg::data_w-1:0] in_data,
    input logic in_valid,
    output logic in_ready,
    output logic [classifier_pkg::class_w-1:0] answer,
    output logic answer_valid
);

    token_stream_if parser_to_fifo ();
    token_stream_if fifo_to_dense ();

    // tags bytes of a frame, drops anything before the header
    frame_parser u_parser (
        .clk(clk),
        .reset(reset),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .tokens(parser_to_fifo.source)
    );

    // soaks up bytes while the scores are scanned
    token_fifo u_fifo (
        .clk(clk),
        .reset(reset),
        .upstream(parser_to_fifo.sink),
        .downstream(fifo_to_dense.source)
    );

    dense_argmax u_dense (
        .clk(clk),
        .reset(reset),
        .tokens(fifo_to_dense.sink),
        .answer(answer),
        .answer_valid(answer_valid)
    );

endmodule

//--- testbench/classifier_checker.sv
`timescale 1ns/1ps

module classifier_checker (
    input logic clk,
    input logic reset,
    input logic in_valid,
    input logic in_ready,
    input logic [classifier_pkg::class_w-1:0] answer,
    input logic answer_valid
);

    typedef logic [classifier_pkg::num_classes*classifier_pkg::data_w-1:0] bytes_t;

    int pass_count = 0;
    int fail_count = 0;
    int trace_errors = 0;
    int stall_cycles = 0;
    string name_q [$];
    int expect_q [$];
    logic prev_valid = 1'b0;
    logic after_reset = 1'b0;

    // first class reaching the highest 49*f*w + b
    function automatic int best_class(input int f, input bytes_t w, input bytes_t b);
        int score;
        int best;
        int best_score;
        best = 0;
        best_score = -1;
        for (int c = 0; c < classifier_pkg::num_classes; c++) begin
            score = classifier_pkg::num_features * f * int'(w[c*8 +: 8]) + int'(b[c*8 +: 8]);
            if (score > best_score) begin
                best_score = score;
                best = c;
            end
        end
        return best;
    endfunction

    task automatic expect_frame(input string name, input int f, input bytes_t w,
                                input bytes_t b, input int listed);
        int computed;
        computed = best_class(f, w, b);
        if (computed != listed) begin
            $display("trace error: test %0s lists class %0d but its scores give class %0d",
                     name, listed, computed);
            trace_errors++;
        end
        name_q.push_back(name);
        expect_q.push_back(computed);
    endtask

    function automatic int outstanding();
        return name_q.size();
    endfunction

    function automatic int report_missing();
        foreach (name_q[i]) begin
            $display("test %0s never produced an answer", name_q[i]);
        end
        return name_q.size();
    endfunction

    // back-to-back frames must have stalled the input during a scan
    task automatic check_backpressure();
        if (stall_cycles == 0) begin
            $display("in_ready never went low while a byte was waiting");
            fail_count++;
        end
    endtask

    // sampled mid-cycle, answers come back in frame order
    always @(negedge clk) begin
        string name;
        int expected;
        if (reset) begin
            prev_valid = 1'b0;
            after_reset = 1'b1;
        end else begin
            // input side open from the first edge after reset
            if (after_reset && !in_ready) begin
                $display("in_ready was low in the first cycle after reset");
                fail_count++;
            end
            after_reset = 1'b0;
            if (in_valid && !in_ready) begin
                stall_cycles++;
            end
            if (answer_valid && !prev_valid) begin
                if (name_q.size() == 0) begin
                    $display("an answer of class %0d arrived with no frame outstanding", answer);
                    fail_count++;
                end else begin
                    name = name_q.pop_front();
                    expected = expect_q.pop_front();
                    if (answer !== 4'(expected)) begin
                        $display("ERR %0t: test %0s answered class %0d, expected class %0d",
                                 $time, name, answer, expected);
                        fail_count++;
                    end else begin
                        $display("pass %0s: class %0d at %0t", name, answer, $time);
                        pass_count++;
                    end
                end
            end
            prev_valid = answer_valid;
        end
    end

endmodule

//--- testbench/tb_digit_classifier.sv
`timescale 1ns/1ps

module tb_digit_classifier;

    localparam int clk_period = 4;
    localparam int reset_cycles = 8;
    localparam int drive_delay = 1;
    localparam int seed = 47102;
    localparam int max_tests = 32;
    localparam int max_gap = 3;
    localparam int ncls = classifier_pkg::num_classes;
    localparam int nfeat = classifier_pkg::num_features;
    // header, features, class-major weights, biases
    localparam int frame_bytes = 1 + nfeat + nfeat * ncls + ncls;
    localparam string trace_path = "testbench/classifier_trace.txt";

    typedef logic [ncls*classifier_pkg::data_w-1:0] bytes_t;

    logic clk;
    logic reset;
    logic [classifier_pkg::data_w-1:0] in_data;
    logic in_valid;
    logic in_ready;
    logic [classifier_pkg::class_w-1:0] answer;
    logic answer_valid;

    string test_name [max_tests];
    int junk_len [max_tests];
    int feat_val [max_tests];
    int weight_val [max_tests][ncls];
    int bias_val [max_tests][ncls];
    int gap_mode [max_tests];
    int listed [max_tests];
    int num_tests = 0;
    int cycle_limit = 0;
    int cycle_count = 0;

    digit_classifier i_digit_classifier (
        .clk(clk),
        .reset(reset),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .answer(answer),
        .answer_valid(answer_valid)
    );

    classifier_checker u_checker (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .answer(answer),
        .answer_valid(answer_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic read_trace(output bit ok);
        int fd;
        int code;
        int n;
        string line;
        ok = 1'b0;
        fd = $fopen(trace_path, "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd) && num_tests < max_tests) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line,
                    "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                    test_name[num_tests], junk_len[num_tests], feat_val[num_tests],
                    weight_val[num_tests][0], weight_val[num_tests][1],
                    weight_val[num_tests][2], weight_val[num_tests][3],
                    weight_val[num_tests][4], weight_val[num_tests][5],
                    weight_val[num_tests][6], weight_val[num_tests][7],
                    weight_val[num_tests][8], weight_val[num_tests][9],
                    bias_val[num_tests][0], bias_val[num_tests][1], bias_val[num_tests][2],
                    bias_val[num_tests][3], bias_val[num_tests][4], bias_val[num_tests][5],
                    bias_val[num_tests][6], bias_val[num_tests][7], bias_val[num_tests][8],
                    bias_val[num_tests][9], gap_mode[num_tests], listed[num_tests]);
                if (n != 25) begin
                    $display("trace line could not be read: %0s", line);
                    $fclose(fd);
                    return;
                end
                // worst case is one byte every four cycles
                cycle_limit += (junk_len[num_tests] + frame_bytes) * 4 + 100;
                num_tests++;
            end
        end
        $fclose(fd);
        ok = (num_tests > 0);
    endtask

    task automatic abort_run(input string reason);
        int missing;
        missing = u_checker.report_missing();
        $display("%0s", reason);
        $display("summary: %0d passed, %0d failed", u_checker.pass_count,
                 u_checker.fail_count + u_checker.trace_errors + missing);
        $display("Something failed");
        $finish;
    endtask

    // called a little after a rising edge, returns at the same point
    task automatic send_byte(input logic [7:0] value, input int gap);
        bit taken;
        if (gap != 0) begin
            in_valid = 1'b0;
            repeat ($urandom % (max_gap + 1)) begin
                @(posedge clk);
                #drive_delay;
            end
        end
        in_data = value;
        in_valid = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            // in_ready only moves on the edge
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #drive_delay;
        end
        in_valid = 1'b0;
    endtask

    task automatic send_frame(input int t);
        bytes_t w_bytes;
        bytes_t b_bytes;
        logic [7:0] junk;
        for (int c = 0; c < ncls; c++) begin
            w_bytes[c*8 +: 8] = 8'(weight_val[t][c]);
            b_bytes[c*8 +: 8] = 8'(bias_val[t][c]);
        end
        u_checker.expect_frame(test_name[t], feat_val[t], w_bytes, b_bytes, listed[t]);
        for (int j = 0; j < junk_len[t]; j++) begin
            junk = 8'($urandom);
            if (junk == classifier_pkg::header_code) begin
                junk = junk + 8'd1;
            end
            send_byte(junk, gap_mode[t]);
        end
        send_byte(classifier_pkg::header_code, gap_mode[t]);
        for (int k = 0; k < nfeat; k++) begin
            send_byte(8'(feat_val[t]), gap_mode[t]);
        end
        for (int c = 0; c < ncls; c++) begin
            for (int k = 0; k < nfeat; k++) begin
                send_byte(w_bytes[c*8 +: 8], gap_mode[t]);
            end
        end
        for (int c = 0; c < ncls; c++) begin
            send_byte(b_bytes[c*8 +: 8], gap_mode[t]);
        end
    endtask

    // watchdog sized from the trace
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        abort_run($sformatf("timeout: no finish after %0d cycles", cycle_count));
    end

    initial begin
        bit trace_ok;
        int failures;
        in_data = '0;
        in_valid = 1'b0;
        reset = 1'b1;
        void'($urandom(seed));
        read_trace(trace_ok);
        if (!trace_ok) begin
            abort_run("trace file missing, empty or malformed");
        end else begin
            repeat (reset_cycles) @(posedge clk);
            #drive_delay;
            reset = 1'b0;
            // frames go out back to back so the scans push back on the input
            for (int t = 0; t < num_tests; t++) begin
                send_frame(t);
            end
            while (u_checker.outstanding() != 0) begin
                @(posedge clk);
            end
            repeat (4) @(posedge clk);
            u_checker.check_backpressure();
            failures = u_checker.fail_count + u_checker.trace_errors;
            $display("summary: %0d passed, %0d failed", u_checker.pass_count, failures);
            if (failures == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

endmodule

//--- classifier_project.f
hw/classifier_pkg.sv
hw/token_stream_if.sv
hw/frame_parser.sv
hw/token_fifo.sv
hw/dense_argmax.sv
hw/digit_classifier.sv
testbench/classifier_checker.sv
testbench/tb_digit_classifier.sv

//--- Bender.yml
package:
  name: classifier_project

sources:
  # design, in compile order
  - files:
      - hw/classifier_pkg.sv
      - hw/token_stream_if.sv
      - hw/frame_parser.sv
      - hw/token_fifo.sv
      - hw/dense_argmax.sv
      - hw/digit_classifier.sv

  # simulation only
  - target: test
    files:
      - testbench/classifier_checker.sv
      - testbench/tb_digit_classifier.sv

//--- testbench/classifier_trace.txt
# name junk feature w0 w1 w2 w3 w4 w5 w6 w7 w8 w9 b0 b1 b2 b3 b4 b5 b6 b7 b8 b9 gap expected
# gap 0 sends bytes back to back, gap 1 adds 0 to 3 idle cycles before each byte
basic_distinct 0 2 5 9 3 7 11 2 8 6 4 1 0 0 0 0 0 0 0 0 0 0 0 4
basic_gaps 0 7 1 2 3 4 5 6 7 8 200 9 0 0 0 0 0 0 0 0 0 0 1 8
bias_decides 0 4 10 10 10 10 10 10 10 10 10 10 3 7 2 9 1 0 5 8 6 4 0 3
bias_vs_weight 0 1 3 3 3 3 3 3 3 3 3 4 50 0 0 0 0 0 0 0 0 0 0 0
tie_weights 0 1 2 5 5 1 0 3 4 5 0 1 0 0 0 0 0 0 0 0 0 0 0 1
tie_bias 0 3 4 4 4 4 4 4 4 4 4 4 0 0 6 0 6 0 0 0 0 6 1 2
junk_short 5 2 5 9 3 7 11 2 8 6 4 1 0 0 0 0 0 0 0 0 0 0 0 4
junk_gaps 12 2 5 9 3 7 11 2 8 6 4 1 0 0 0 0 0 0 0 0 0 0 1 4
last_class 0 9 1 1 1 1 1 1 1 1 1 2 0 0 0 0 0 0 0 0 0 0 1 9
all_zero 0 0 9 8 7 6 5 4 3 2 1 0 0 0 0 0 0 0 0 0 0 0 0 0
full_range 0 255 254 254 254 254 254 254 255 254 254 254 255 255 255 255 255 255 255 255 255 255 0 6
full_tie 0 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 255 1 0
